/* scarv_cop_settings.svh */
/*
 * SCARV crypto co-processor constants
 * Custom opcode, register count, function numbers and result codes
 */
`ifndef SCARV_COP_SETTINGS_SVH
`define SCARV_COP_SETTINGS_SVH

// custom-0 major opcode
`define SCARV_COP_OPCODE        7'b0001011

`define SCARV_COP_NREGS         16          // Co-processor registers

// Function field, insn[31:28]
`define SCARV_COP_FN_MV2COP     4'd0        // GPR word into COP reg
`define SCARV_COP_FN_MV2GPR     4'd1        // COP reg back to GPR
`define SCARV_COP_FN_XOR        4'd2
`define SCARV_COP_FN_ADD        4'd3
`define SCARV_COP_FN_ROR        4'd4        // Rotate right by imm
`define SCARV_COP_FN_LW         4'd5
`define SCARV_COP_FN_SW         4'd6

// Result codes on cop_result
`define SCARV_COP_RES_OK        3'd0
`define SCARV_COP_RES_ILLEGAL   3'd1
`define SCARV_COP_RES_BUS_ERROR 3'd2
`define SCARV_COP_RES_ABORTED   3'd3
`define SCARV_COP_RES_MISALIGN  3'd4

`endif

/* scarv_cop_pkg.sv */
/*
 * SCARV crypto co-processor types
 * Word and index typedefs, operation and memory-stage encodings
 */
`default_nettype none

package scarv_cop_pkg;

    typedef logic [31:0] cop_word_t;      // Data word
    typedef logic [3:0]  cop_reg_addr_t;  // COP register index
    typedef logic [4:0]  gpr_addr_t;      // CPU register index
    typedef logic [7:0]  cop_imm_t;       // Signed offset or rotate amount
    typedef logic [2:0]  cop_result_t;    // Result code

    // Decoded operation
    typedef enum logic [2:0] {
        OP_MV2COP,
        OP_MV2GPR,
        OP_XOR,
        OP_ADD,
        OP_ROR,
        OP_LW,
        OP_SW,
        OP_BAD      // Bad opcode or function
    } cop_op_t;

    // Memory/response stage
    typedef enum logic [1:0] {
        MS_IDLE,    // Empty
        MS_ACCESS,  // Bus access running
        MS_HOLD     // Finished and waiting for the response slot
    } mem_state_t;

endpackage

`default_nettype wire

/* scarv_cop_decode.sv */
/*
 * SCARV co-processor decode stage
 * Accepts instructions over the CPU req/ack handshake, classifies them
 * and registers the fields for the execute stage
 */
`timescale 1ns/1ps
`default_nettype none
`include "scarv_cop_settings.svh"

module scarv_cop_decode import scarv_cop_pkg::*; (
    input  wire            g_clk,
    input  wire            rst_n,
    input  wire            cpu_insn_req,
    input  wire cop_word_t cpu_insn_enc,
    input  wire cop_word_t cpu_rs1,
    input  wire            cpu_abort_req,
    input  wire            dec_ready,
    output logic           cop_insn_ack,
    output logic           dec_valid,
    output cop_op_t        dec_op,
    output cop_reg_addr_t  dec_rs1,
    output cop_reg_addr_t  dec_rs2,
    output gpr_addr_t      dec_rd,
    output cop_imm_t       dec_imm,
    output cop_word_t      dec_gpr_data,
    output logic           dec_abort
);

    cop_op_t op_c;      // Classified operation
    logic    rdy_q;     // Set one edge after reset
    logic    load;

    always_comb begin
        op_c = OP_BAD;
        if (cpu_insn_enc[6:0] == `SCARV_COP_OPCODE) begin
            case (cpu_insn_enc[31:28])
                `SCARV_COP_FN_MV2COP: op_c = OP_MV2COP;
                `SCARV_COP_FN_MV2GPR: op_c = OP_MV2GPR;
                `SCARV_COP_FN_XOR:    op_c = OP_XOR;
                `SCARV_COP_FN_ADD:    op_c = OP_ADD;
                `SCARV_COP_FN_ROR:    op_c = OP_ROR;
                `SCARV_COP_FN_LW:     op_c = OP_LW;
                `SCARV_COP_FN_SW:     op_c = OP_SW;
                default:              op_c = OP_BAD;  // Unknown function
            endcase
        end
    end

    // Ready when empty or handing over to execute
    assign cop_insn_ack = rdy_q && (!dec_valid || dec_ready);
    assign load         = cpu_insn_req && cop_insn_ack;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            rdy_q     <= 1'b0;
            dec_valid <= 1'b0;
            dec_abort <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
            if (load) begin
                dec_valid <= 1'b1;
                dec_abort <= cpu_abort_req;     // Abort in the accept cycle counts
            end else begin
                if (dec_ready)
                    dec_valid <= 1'b0;
                dec_abort <= dec_abort | cpu_abort_req;
            end
        end
    end

    // Instruction fields
    always_ff @(posedge g_clk) begin
        if (load) begin
            dec_op       <= op_c;
            dec_rs2      <= cpu_insn_enc[27:24];
            dec_rs1      <= cpu_insn_enc[23:20];
            dec_imm      <= cpu_insn_enc[19:12];
            dec_rd       <= cpu_insn_enc[11:7];
            dec_gpr_data <= cpu_rs1;            // Source for MV2COP
        end
    end

    // CPU holds the encoding until acknowledged
    a_enc_stable: assert property (@(posedge g_clk) disable iff (!rst_n)
        cpu_insn_req && !cop_insn_ack |=> $stable(cpu_insn_enc));

endmodule

`default_nettype wire

/* scarv_cop_regfile.sv */
/*
 * SCARV co-processor register file
 * Sixteen words, two combinational read ports, one clocked write port
 */
`timescale 1ns/1ps
`default_nettype none
`include "scarv_cop_settings.svh"

module scarv_cop_regfile import scarv_cop_pkg::*; (
    input  wire                g_clk,
    input  wire                rst_n,
    input  wire cop_reg_addr_t rd_addr_a,
    input  wire cop_reg_addr_t rd_addr_b,
    input  wire                wr_en,
    input  wire cop_reg_addr_t wr_addr,
    input  wire cop_word_t     wr_data,
    output cop_word_t          rd_data_a,
    output cop_word_t          rd_data_b
);

    cop_word_t regs [`SCARV_COP_NREGS];

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SCARV_COP_NREGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;   // Write-back from memory stage
        end
    end

    // No bypass as the interlock orders reads after writes
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

/* scarv_cop_execute.sv */
/*
 * SCARV co-processor execute stage
 * Reads operands under the register interlock, computes results and
 * load/store addresses, and assigns the result code
 */
`timescale 1ns/1ps
`default_nettype none
`include "scarv_cop_settings.svh"

module scarv_cop_execute import scarv_cop_pkg::*; (
    input  wire                g_clk,
    input  wire                rst_n,
    input  wire                dec_valid,
    input  wire cop_op_t       dec_op,
    input  wire cop_reg_addr_t dec_rs1,
    input  wire cop_reg_addr_t dec_rs2,
    input  wire gpr_addr_t     dec_rd,
    input  wire cop_imm_t      dec_imm,
    input  wire cop_word_t     dec_gpr_data,
    input  wire                dec_abort,
    input  wire                cpu_abort_req,
    input  wire cop_word_t     rf_data_a,
    input  wire cop_word_t     rf_data_b,
    input  wire                wb_pending,
    input  wire cop_reg_addr_t wb_addr,
    input  wire                ex_ready,
    output logic               dec_ready,
    output cop_reg_addr_t      rf_addr_a,
    output cop_reg_addr_t      rf_addr_b,
    output logic               ex_valid,
    output cop_op_t            ex_op,
    output gpr_addr_t          ex_rd,
    output cop_word_t          ex_result,
    output cop_word_t          ex_addr,
    output cop_word_t          ex_store_data,
    output cop_result_t        ex_status
);

    logic        uses_a, uses_b;    // Source register use per op
    logic        ex_writes;         // Held item will write a COP reg
    logic        hazard;
    logic        load;
    logic [63:0] ror_wide;
    cop_word_t   addr_c, result_c;
    cop_result_t status_c;

    assign rf_addr_a = dec_rs1;
    assign rf_addr_b = dec_rs2;

    assign uses_a    = dec_op inside {OP_MV2GPR, OP_XOR, OP_ADD, OP_ROR, OP_LW, OP_SW};
    assign uses_b    = dec_op inside {OP_XOR, OP_ADD, OP_SW};
    assign ex_writes = (ex_op inside {OP_MV2COP, OP_XOR, OP_ADD, OP_ROR, OP_LW}) &&
                       (ex_status == `SCARV_COP_RES_OK);

    // Interlock on writers in execute or memory
    assign hazard = (uses_a && ((wb_pending && wb_addr == dec_rs1) ||
                                (ex_valid && ex_writes && ex_rd[3:0] == dec_rs1))) ||
                    (uses_b && ((wb_pending && wb_addr == dec_rs2) ||
                                (ex_valid && ex_writes && ex_rd[3:0] == dec_rs2)));

    assign dec_ready = (!ex_valid || ex_ready) && !hazard;
    assign load      = dec_valid && dec_ready;

    assign addr_c   = rf_data_a + {{24{dec_imm[7]}}, dec_imm};  // Signed byte offset
    assign ror_wide = {rf_data_a, rf_data_a} >> dec_imm[4:0];

    always_comb begin
        case (dec_op)
            OP_MV2COP: result_c = dec_gpr_data;
            OP_XOR:    result_c = rf_data_a ^ rf_data_b;
            OP_ADD:    result_c = rf_data_a + rf_data_b;
            OP_ROR:    result_c = ror_wide[31:0];
            default:   result_c = rf_data_a;         // MV2GPR
        endcase
    end

    always_comb begin
        if (dec_abort || cpu_abort_req)
            status_c = `SCARV_COP_RES_ABORTED;
        else if (dec_op == OP_BAD)
            status_c = `SCARV_COP_RES_ILLEGAL;
        else if ((dec_op == OP_LW || dec_op == OP_SW) && addr_c[1:0] != 2'b00)
            status_c = `SCARV_COP_RES_MISALIGN;
        else
            status_c = `SCARV_COP_RES_OK;
    end

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_status <= `SCARV_COP_RES_OK;
        end else if (load) begin
            ex_valid  <= 1'b1;
            ex_status <= status_c;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end else if (ex_valid && cpu_abort_req) begin
            ex_status <= `SCARV_COP_RES_ABORTED;    // Held item aborted
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            ex_op         <= dec_op;
            ex_rd         <= dec_rd;
            ex_result     <= result_c;
            ex_addr       <= addr_c;
            ex_store_data <= rf_data_b;
        end
    end

    // Only an abort may change a held item before memory takes it
    a_ex_hold: assert property (@(posedge g_clk) disable iff (!rst_n)
        ex_valid && !ex_ready |=> ex_valid &&
            $stable({ex_op, ex_rd, ex_result, ex_addr, ex_store_data}) &&
            ($stable(ex_status) || ex_status == `SCARV_COP_RES_ABORTED));

endmodule

`default_nettype wire

/* scarv_cop_mem.sv */
/*
 * SCARV co-processor memory/response stage
 * Runs word bus accesses, writes back the register file and holds
 * the CPU response under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none
`include "scarv_cop_settings.svh"

module scarv_cop_mem import scarv_cop_pkg::*; (
    input  wire              g_clk,
    input  wire              rst_n,
    input  wire              ex_valid,
    input  wire cop_op_t     ex_op,
    input  wire gpr_addr_t   ex_rd,
    input  wire cop_word_t   ex_result,
    input  wire cop_word_t   ex_addr,
    input  wire cop_word_t   ex_store_data,
    input  wire cop_result_t ex_status,
    input  wire              cpu_abort_req,
    input  wire cop_word_t   cop_mem_rdata,
    input  wire              cop_mem_stall,
    input  wire              cop_mem_error,
    input  wire              cpu_insn_ack,
    output logic             ex_ready,
    output logic             mem_busy,
    output logic             wb_pending,
    output cop_reg_addr_t    wb_addr,
    output logic             rf_wen,
    output cop_reg_addr_t    rf_waddr,
    output cop_word_t        rf_wdata,
    output logic             cop_mem_cen,
    output logic             cop_mem_wen,
    output cop_word_t        cop_mem_addr,
    output cop_word_t        cop_mem_wdata,
    output logic [3:0]       cop_mem_ben,
    output logic             cop_insn_rsp,
    output logic             cop_wen,
    output gpr_addr_t        cop_waddr,
    output cop_word_t        cop_wdata,
    output cop_result_t      cop_result
);

    mem_state_t  state_q;
    cop_op_t     m_op;
    gpr_addr_t   m_rd;
    cop_word_t   m_data, m_addr, m_wdata;
    cop_result_t m_status, fin_status;
    cop_word_t   fin_data;
    logic        rsp_free, bus_done, complete, accept, to_access, m_writes, rsp_wen;

    assign rsp_free  = !cop_insn_rsp || cpu_insn_ack;   // Response slot free this edge
    assign bus_done  = (state_q == MS_ACCESS) && !cop_mem_stall;
    assign complete  = ((state_q == MS_HOLD) || bus_done) && rsp_free;
    assign ex_ready  = (state_q == MS_IDLE) || complete;
    assign accept    = ex_valid && ex_ready;
    assign to_access = (ex_status == `SCARV_COP_RES_OK) && !cpu_abort_req &&
                       (ex_op == OP_LW || ex_op == OP_SW);
    assign m_writes  = m_op inside {OP_MV2COP, OP_XOR, OP_ADD, OP_ROR, OP_LW};
    assign mem_busy  = state_q != MS_IDLE;

    always_comb begin
        if (m_status != `SCARV_COP_RES_OK)
            fin_status = m_status;
        else if (cpu_abort_req)
            fin_status = `SCARV_COP_RES_ABORTED;   // Load data dropped
        else if (bus_done && cop_mem_error)
            fin_status = `SCARV_COP_RES_BUS_ERROR;
        else
            fin_status = `SCARV_COP_RES_OK;
        fin_data = (state_q == MS_ACCESS && m_op == OP_LW) ? cop_mem_rdata : m_data;
    end

    assign wb_pending = mem_busy && m_writes && (m_status == `SCARV_COP_RES_OK);
    assign wb_addr    = m_rd[3:0];

    // Register file write-back
    assign rf_wen   = complete && m_writes && (fin_status == `SCARV_COP_RES_OK);
    assign rf_waddr = m_rd[3:0];
    assign rf_wdata = fin_data;
    assign rsp_wen  = (m_op == OP_MV2GPR) && (fin_status == `SCARV_COP_RES_OK);

    // Bus request straight from the held item
    assign cop_mem_cen   = state_q == MS_ACCESS;
    assign cop_mem_wen   = cop_mem_cen && (m_op == OP_SW);
    assign cop_mem_addr  = m_addr;
    assign cop_mem_wdata = m_wdata;
    assign cop_mem_ben   = cop_mem_wen ? 4'hF : 4'h0;   // Word stores only

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= MS_IDLE;
            m_status <= `SCARV_COP_RES_OK;
        end else if (accept) begin
            state_q  <= to_access ? MS_ACCESS : MS_HOLD;
            m_status <= cpu_abort_req ? `SCARV_COP_RES_ABORTED : ex_status;
        end else if (complete) begin
            state_q <= MS_IDLE;
        end else if (bus_done) begin
            state_q  <= MS_HOLD;                    // Response slot still full
            m_status <= fin_status;
        end else if (mem_busy && cpu_abort_req) begin
            m_status <= `SCARV_COP_RES_ABORTED;     // Running access still completes
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            m_op    <= ex_op;
            m_rd    <= ex_rd;
            m_data  <= ex_result;
            m_addr  <= ex_addr;
            m_wdata <= ex_store_data;
        end else if (bus_done) begin
            m_data <= fin_data;     // Keep load data while holding
        end
    end

    // Response register
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
            cop_waddr    <= '0;
            cop_wdata    <= '0;
            cop_result   <= `SCARV_COP_RES_OK;
        end else if (complete) begin
            cop_insn_rsp <= 1'b1;
            cop_result   <= fin_status;
            cop_wen      <= rsp_wen;
            cop_waddr    <= rsp_wen ? m_rd : '0;
            cop_wdata    <= rsp_wen ? fin_data : '0;
        end else if (cpu_insn_ack) begin
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
        end
    end

    a_bus_hold: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_mem_cen && cop_mem_stall |=> cop_mem_cen &&
            $stable({cop_mem_wen, cop_mem_addr, cop_mem_wdata, cop_mem_ben}));

    a_rsp_hold: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp &&
            $stable({cop_result, cop_wen, cop_waddr, cop_wdata}));

endmodule

`default_nettype wire

/* scarv_cop_top.sv */
/*
 * SCARV crypto co-processor top level
 * Decode, execute and memory/response stages around the register file
 */
`timescale 1ns/1ps
`default_nettype none

module scarv_cop_top import scarv_cop_pkg::*; (
    input  wire              g_clk,          // Global clock
    output logic             g_clk_req,      // Clock request
    input  wire              rst_n,          // Async active low reset

    input  wire              cpu_insn_req,   // Instruction request
    output logic             cop_insn_ack,
    input  wire              cpu_abort_req,  // Abort all in flight
    input  wire cop_word_t   cpu_insn_enc,
    input  wire cop_word_t   cpu_rs1,        // CPU source word

    output logic             cop_wen,        // GPR write enable
    output gpr_addr_t        cop_waddr,
    output cop_word_t        cop_wdata,
    output cop_result_t      cop_result,
    output logic             cop_insn_rsp,   // Instruction finished
    input  wire              cpu_insn_ack,   // Response acknowledge

    output logic             cop_mem_cen,
    output logic             cop_mem_wen,
    output cop_word_t        cop_mem_addr,   // Word aligned
    output cop_word_t        cop_mem_wdata,
    input  wire cop_word_t   cop_mem_rdata,
    output logic [3:0]       cop_mem_ben,
    input  wire              cop_mem_stall,
    input  wire              cop_mem_error
);

    // Decode to execute
    logic          dec_valid, dec_ready, dec_abort;
    cop_op_t       dec_op;
    cop_reg_addr_t dec_rs1, dec_rs2;
    gpr_addr_t     dec_rd;
    cop_imm_t      dec_imm;
    cop_word_t     dec_gpr_data;

    // Register file
    cop_reg_addr_t rf_addr_a, rf_addr_b, rf_waddr;
    cop_word_t     rf_data_a, rf_data_b, rf_wdata;
    logic          rf_wen;

    // Execute to memory
    logic          ex_valid, ex_ready, mem_busy, wb_pending;
    cop_reg_addr_t wb_addr;
    cop_op_t       ex_op;
    gpr_addr_t     ex_rd;
    cop_word_t     ex_result, ex_addr, ex_store_data;
    cop_result_t   ex_status;

    // Clock needed while any stage holds work
    assign g_clk_req = cpu_insn_req | dec_valid | ex_valid | mem_busy | cop_insn_rsp;

    scarv_cop_decode i_decode (
        .g_clk, .rst_n, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_abort_req,
        .dec_ready, .cop_insn_ack, .dec_valid, .dec_op, .dec_rs1, .dec_rs2,
        .dec_rd, .dec_imm, .dec_gpr_data, .dec_abort
    );

    scarv_cop_regfile i_regfile (
        .g_clk, .rst_n, .rd_addr_a(rf_addr_a), .rd_addr_b(rf_addr_b),
        .wr_en(rf_wen), .wr_addr(rf_waddr), .wr_data(rf_wdata),
        .rd_data_a(rf_data_a), .rd_data_b(rf_data_b)
    );

    scarv_cop_execute i_execute (
        .g_clk, .rst_n, .dec_valid, .dec_op, .dec_rs1, .dec_rs2, .dec_rd,
        .dec_imm, .dec_gpr_data, .dec_abort, .cpu_abort_req, .rf_data_a,
        .rf_data_b, .wb_pending, .wb_addr, .ex_ready, .dec_ready, .rf_addr_a,
        .rf_addr_b, .ex_valid, .ex_op, .ex_rd, .ex_result, .ex_addr,
        .ex_store_data, .ex_status
    );

    scarv_cop_mem i_mem (
        .g_clk, .rst_n, .ex_valid, .ex_op, .ex_rd, .ex_result, .ex_addr,
        .ex_store_data, .ex_status, .cpu_abort_req, .cop_mem_rdata,
        .cop_mem_stall, .cop_mem_error, .cpu_insn_ack, .ex_ready, .mem_busy,
        .wb_pending, .wb_addr, .rf_wen, .rf_waddr, .rf_wdata, .cop_mem_cen,
        .cop_mem_wen, .cop_mem_addr, .cop_mem_wdata, .cop_mem_ben,
        .cop_insn_rsp, .cop_wen, .cop_waddr, .cop_wdata, .cop_result
    );

endmodule

`default_nettype wire

/* tb_scarv_cop_top.sv */
/*
 * Testbench for the SCARV crypto co-processor
 * CPU driver, word memory model, reference register model and
 * response checking by concurrent assertions
 */
`timescale 1ns/1ps
`default_nettype none
`include "scarv_cop_settings.svh"

module tb_scarv_cop_top import scarv_cop_pkg::*; ();

    localparam int N_INSN = 150;            // Upper bound of issued instructions
    localparam int LIMIT  = 4 * N_INSN * 20;
    localparam int N_ABORT_OPS = 4;

    logic g_clk, rst_n, g_clk_req;
    logic cpu_insn_req, cop_insn_ack, cpu_abort_req, cpu_insn_ack;
    cop_word_t cpu_insn_enc, cpu_rs1;
    logic cop_wen, cop_insn_rsp;
    gpr_addr_t cop_waddr;
    cop_word_t cop_wdata;
    cop_result_t cop_result;
    logic cop_mem_cen, cop_mem_wen, cop_mem_stall, cop_mem_error;
    cop_word_t cop_mem_addr, cop_mem_wdata, cop_mem_rdata;
    logic [3:0] cop_mem_ben;

    integer seed = 20862;
    int cycles = 0;
    int n_abort = 0;
    logic bp_en = 1'b0, stall_en = 1'b0, err_en = 1'b0;   // Stimulus modes

    cop_word_t tb_mem [256];    // Memory seen by the DUT
    cop_word_t m_mem  [256];    // Reference memory
    cop_word_t m_reg  [16];     // Reference registers
    logic [40:0] exp_q [$];     // {result, wen, waddr, wdata}
    logic        exp_valid = 1'b0;
    cop_result_t exp_result;
    logic        exp_wen;
    gpr_addr_t   exp_waddr;
    cop_word_t   exp_wdata;

    scarv_cop_top i_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;     // 40 ns period
    end

    task automatic fail_value(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic cop_word_t rand32();
        return $random(seed);
    endfunction

    function automatic cop_word_t make_insn(input logic [3:0] fn, input cop_reg_addr_t rs2,
                                            input cop_reg_addr_t rs1, input cop_imm_t imm,
                                            input gpr_addr_t rd);
        return {fn, rs2, rs1, imm, rd, `SCARV_COP_OPCODE};
    endfunction

    function automatic logic [40:0] pack_exp(input cop_result_t res, input logic wen,
                                             input gpr_addr_t wa, input cop_word_t wd);
        return {res, wen, wa, wd};
    endfunction

    // Offer one instruction and push its expectation at the accepting edge
    task automatic send(input cop_word_t enc, input cop_word_t rs1v, input logic [40:0] e);
        @(negedge g_clk);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1v;
        do @(posedge g_clk); while (!cop_insn_ack);
        exp_q.push_back(e);
    endtask

    task automatic release_req();
        @(negedge g_clk);
        cpu_insn_req = 1'b0;
    endtask

    task automatic drain();
        release_req();
        while (exp_q.size() != 0 || cop_insn_rsp)
            @(posedge g_clk);
    endtask

    // Reference model step before the issue
    task automatic issue_op(input logic [3:0] fn, input gpr_addr_t rd, input cop_reg_addr_t rs1,
                            input cop_reg_addr_t rs2, input cop_imm_t imm, input cop_word_t gval);
        cop_word_t   a, b, addr;
        logic [4:0]  sh;
        cop_result_t res;
        logic        wen;
        gpr_addr_t   wa;
        cop_word_t   wd;
        a    = m_reg[rs1];
        b    = m_reg[rs2];
        addr = a + {{24{imm[7]}}, imm};
        sh   = imm[4:0];
        res  = `SCARV_COP_RES_OK;
        wen  = 1'b0;
        wa   = '0;
        wd   = '0;
        case (fn)
            `SCARV_COP_FN_MV2COP: m_reg[rd[3:0]] = gval;
            `SCARV_COP_FN_MV2GPR: begin
                wen = 1'b1;
                wa  = rd;
                wd  = a;
            end
            `SCARV_COP_FN_XOR: m_reg[rd[3:0]] = a ^ b;
            `SCARV_COP_FN_ADD: m_reg[rd[3:0]] = a + b;
            `SCARV_COP_FN_ROR: m_reg[rd[3:0]] = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
            default: begin      // Loads and stores
                if (addr[1:0] != 2'b00)
                    res = `SCARV_COP_RES_MISALIGN;
                else if (err_en)
                    res = `SCARV_COP_RES_BUS_ERROR;
                else if (fn == `SCARV_COP_FN_LW)
                    m_reg[rd[3:0]] = m_mem[addr[9:2]];
                else
                    m_mem[addr[9:2]] = b;
            end
        endcase
        send(make_insn(fn, rs2, rs1, imm, rd), gval, pack_exp(res, wen, wa, wd));
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < 16; r++)
            issue_op(`SCARV_COP_FN_MV2GPR, 5'(r + 16), 4'(r), 4'd0, 8'd0, '0);
    endtask

    // Back-pressure, stalls and bus errors driven on the falling edge
    always @(negedge g_clk) begin
        cop_word_t r;
        r = rand32();
        cpu_insn_ack  <= bp_en ? (r[0] | r[1]) : 1'b1;
        cop_mem_stall <= stall_en ? r[2] : 1'b0;
        cop_mem_error <= err_en;
        exp_valid     <= exp_q.size() != 0;     // Head view for the next edge
        if (exp_q.size() != 0)
            {exp_result, exp_wen, exp_waddr, exp_wdata} <= exp_q[0];
    end

    assign cop_mem_rdata = tb_mem[cop_mem_addr[9:2]];

    // Byte lanes follow cop_mem_ben when the access completes
    always @(posedge g_clk) begin
        cop_word_t w;
        w = tb_mem[cop_mem_addr[9:2]];
        for (int b = 0; b < 4; b++)
            if (cop_mem_ben[b])
                w[8*b +: 8] = cop_mem_wdata[8*b +: 8];
        if (cop_mem_cen && cop_mem_wen && !cop_mem_stall && !cop_mem_error)
            tb_mem[cop_mem_addr[9:2]] <= w;
    end

    // Response monitor
    always @(posedge g_clk) begin
        if (rst_n && cop_insn_rsp && cpu_insn_ack) begin
            if (exp_q.size() == 0) begin
                fail_plain("Response arrived with no instruction outstanding");
            end else begin
                if (cop_result == `SCARV_COP_RES_ABORTED)
                    n_abort <= n_abort + 1;
                void'(exp_q.pop_front());
            end
        end
    end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
            fail_plain("Timeout, the run took longer than its cycle limit");
    end

    a_rsp_match: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_insn_rsp && cpu_insn_ack |-> exp_valid && cop_result == exp_result &&
            cop_wen == exp_wen && (!exp_wen || (cop_waddr == exp_waddr &&
            cop_wdata == exp_wdata)))
        else fail_value("response differs from reference model");

    a_rsp_stable: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp &&
            $stable({cop_result, cop_wen, cop_waddr, cop_wdata}))
        else fail_value("response changed before its acknowledge");

    a_rsp_clk_req: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_insn_rsp |-> g_clk_req)
        else fail_value("g_clk_req low during a response");

    // Loads enable no byte lanes
    a_ben: assert property (@(posedge g_clk) disable iff (!rst_n)
        cop_mem_cen && !cop_mem_wen |-> cop_mem_ben == 4'h0)
        else fail_value("byte enables set on a load");

    initial begin
        int t0;
        cop_word_t r;
        rst_n = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1 = '0;
        cpu_abort_req = 1'b0;
        cpu_insn_ack = 1'b1;
        cop_mem_stall = 1'b0;
        cop_mem_error = 1'b0;
        for (int i = 0; i < 256; i++) begin
            tb_mem[i] = i * 32'h9E3779B1 + 32'h1234;    // Fill from whole index
            m_mem[i]  = tb_mem[i];
        end
        for (int i = 0; i < 16; i++)
            m_reg[i] = '0;

        repeat (4) @(negedge g_clk);
        a_reset_idle: assert (!cop_insn_ack && !cop_insn_rsp && !cop_wen && !cop_mem_cen &&
                              !cop_mem_wen && !g_clk_req)
            else fail_value("outputs not idle in reset");
        rst_n = 1'b1;
        @(negedge g_clk);
        a_ack_rise: assert (cop_insn_ack)
            else fail_value("cop_insn_ack did not rise after reset");

        // Moves in and out back to back
        for (int i = 0; i < 16; i++) begin
            issue_op(`SCARV_COP_FN_MV2COP, 5'(i), 4'd0, 4'd0, 8'd0, rand32());
            if (i == 0)
                t0 = cycles;
        end
        a_no_gaps: assert (cycles - t0 == 15)
            else fail_value("gaps between back-to-back transfers");
        read_all_regs();
        drain();

        // Dependent chains through the interlock
        r = rand32();
        for (int i = 0; i < 24; i++) begin
            cop_reg_addr_t prev;
            prev = r[3:0];
            r = rand32();
            issue_op(4'(`SCARV_COP_FN_XOR + (r[9:8] % 3)), {1'b0, r[3:0]}, prev,
                     r[7:4], r[23:16], '0);
        end
        read_all_regs();
        drain();

        // Loads and stores with stalls and back-pressure
        bp_en = 1'b1;
        stall_en = 1'b1;
        issue_op(`SCARV_COP_FN_MV2COP, 5'd1, 4'd0, 4'd0, 8'd0, 32'h200);  // Base
        for (int i = 0; i < 20; i++) begin
            cop_reg_addr_t rr;
            r  = rand32();
            rr = 4'(2 + r[15:8] % 14);
            issue_op(r[0] ? `SCARV_COP_FN_SW : `SCARV_COP_FN_LW, {1'b0, rr}, 4'd1, rr,
                     {r[23:18], 2'b00}, '0);
        end
        read_all_regs();
        drain();
        bp_en = 1'b0;
        stall_en = 1'b0;

        // Error cases that write nothing
        send(make_insn(4'd7, 4'd2, 4'd3, 8'd0, 5'd4), '0,
             pack_exp(`SCARV_COP_RES_ILLEGAL, 1'b0, '0, '0));
        send({make_insn(`SCARV_COP_FN_MV2COP, 4'd0, 4'd0, 8'd0, 5'd5)} ^ 32'h38, '0,
             pack_exp(`SCARV_COP_RES_ILLEGAL, 1'b0, '0, '0));
        issue_op(`SCARV_COP_FN_LW, 5'd6, 4'd1, 4'd0, 8'd1, '0);
        issue_op(`SCARV_COP_FN_SW, 5'd0, 4'd1, 4'd7, 8'd6, '0);
        drain();
        err_en = 1'b1;
        issue_op(`SCARV_COP_FN_LW, 5'd8, 4'd1, 4'd0, 8'd8, '0);
        issue_op(`SCARV_COP_FN_SW, 5'd0, 4'd1, 4'd9, 8'd12, '0);
        drain();
        err_en = 1'b0;
        read_all_regs();
        drain();

        // Abort raised with the first op in flight
        send(make_insn(`SCARV_COP_FN_MV2COP, 4'd0, 4'd0, 8'd0, 5'd10), rand32(),
             pack_exp(`SCARV_COP_RES_ABORTED, 1'b0, '0, '0));
        release_req();
        cpu_abort_req = 1'b1;
        send(make_insn(`SCARV_COP_FN_XOR, 4'd2, 4'd3, 8'd0, 5'd11), '0,
             pack_exp(`SCARV_COP_RES_ABORTED, 1'b0, '0, '0));
        send(make_insn(`SCARV_COP_FN_MV2GPR, 4'd0, 4'd4, 8'd0, 5'd12), '0,
             pack_exp(`SCARV_COP_RES_ABORTED, 1'b0, '0, '0));
        send(make_insn(`SCARV_COP_FN_ADD, 4'd5, 4'd6, 8'd0, 5'd13), '0,
             pack_exp(`SCARV_COP_RES_ABORTED, 1'b0, '0, '0));
        drain();
        @(negedge g_clk);
        cpu_abort_req = 1'b0;
        for (int i = 10; i < 14; i++)
            issue_op(`SCARV_COP_FN_MV2GPR, 5'(i), 4'(i), 4'd0, 8'd0, '0);
        drain();

        for (int i = 0; i < 256; i++) begin
            a_mem_match: assert (tb_mem[i] == m_mem[i])
                else fail_value("memory differs from reference model");
        end
        @(negedge g_clk);
        a_idle_clk_req: assert (!g_clk_req)
            else fail_value("g_clk_req high while idle");
        if (n_abort != N_ABORT_OPS) begin
            fail_plain("Wrong number of aborted responses");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* scarv_cop_top.f */
+incdir+.
scarv_cop_pkg.sv
scarv_cop_decode.sv
scarv_cop_regfile.sv
scarv_cop_execute.sv
scarv_cop_mem.sv
scarv_cop_top.sv
tb_scarv_cop_top.sv

/* Makefile */
# Verilator build and run of the SCARV co-processor testbench

VERILATOR ?= verilator
TOP       ?= tb_scarv_cop_top
FILELIST  ?= scarv_cop_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
